/* verilog.f */
source/m68k_bus_pkg.sv
source/block_mover.sv
source/m68k_bus_adapter.sv
source/m68k_wait_ram.sv
source/mover_system.sv
tb/mover_system_assertions.sv
tb/mover_system_tb.sv

/* tb/mover_system_tb.sv */
/*
 * Block mover subsystem testbench
 * Loads random data through the host port, runs block copies with and
 * without a bus grant in between, and compares the RAM against a
 * big-endian reference copy model.
 */
module mover_system_tb;
    import m68k_bus_pkg::*;

    localparam int WAIT_STATES = 2;
    localparam int RAM_WORDS   = 1024;
    localparam int done_limit  = 5000;      // Cycles allowed per copy
    localparam int grant_limit = 200;       // Cycles allowed for BG

    logic                clk;
    logic                rst;
    logic                start;
    logic [addr_w-1:0]   src_addr;
    logic [addr_w-1:0]   dst_addr;
    logic [15:0]         byte_count;
    logic                supervisor;
    logic                br_n;
    logic                host_we;
    logic [15:0]         host_addr;
    logic [data_w-1:0]   host_wdata;
    logic                busy;
    logic                done;
    logic                bg_n;
    logic                as_n;
    logic [2:0]          fc;
    logic [data_w-1:0]   host_rdata;

    logic [15:0]         image [RAM_WORDS];     // Expected RAM contents
    logic [15:0]         next_image [RAM_WORDS];
    logic [31:0]         rng_state;
    int                  error_count;
    int                  check_count;
    int                  done_count;            // Done pulses seen
    int                  as_low_count;          // Cycles with AS low

    mover_system #(
        .WAIT_STATES (WAIT_STATES),
        .RAM_WORDS   (RAM_WORDS)
    ) mover_system_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .byte_count (byte_count),
        .supervisor (supervisor),
        .br_n       (br_n),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .busy       (busy),
        .done       (done),
        .bg_n       (bg_n),
        .as_n       (as_n),
        .fc         (fc),
        .host_rdata (host_rdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word w after copying count bytes from src to dst (non-overlapping ranges)
    function automatic logic [15:0] expected_word(input int w, input int src,
                                                  input int dst, input int count);
        int          off;
        logic [15:0] src_word;
        off = 2 * w - dst;                      // Byte offset into destination
        if (off < 0 || off >= count) return image[w];
        src_word = image[(src + off) / 2];
        if (off + 1 < count) return src_word;
        return {src_word[15:8], image[w][7:0]}; // Odd tail, upper lane only
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic fill_ram();
        for (int i = 0; i < RAM_WORDS; i++) begin
            rng_state = xorshift32(rng_state);
            @(posedge clk);
            host_we    <= 1'b1;
            host_addr  <= 16'(i);
            host_wdata <= rng_state[15:0];
            image[i]   = rng_state[15:0];
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic host_read(input int idx, output logic [15:0] data);
        @(posedge clk);
        host_addr <= 16'(idx);
        @(posedge clk);                         // RAM registers the word
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic start_copy(input int src, input int dst, input int count, input logic sup);
        @(posedge clk);
        src_addr   <= addr_w'(src);
        dst_addr   <= addr_w'(dst);
        byte_count <= 16'(count);
        supervisor <= sup;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (count != 0) check_value("busy", 16'(busy), 16'h1);
    endtask

    task automatic wait_done(input int base, output logic ok);
        int n;
        n = 0;
        while (done_count == base && n < done_limit) begin
            @(posedge clk);
            n++;
        end
        ok = (done_count != base);
        if (!ok) report_timeout("done after a copy");
    endtask

    task automatic wait_grant(output logic ok);
        int n;
        n = 0;
        while (bg_n && n < grant_limit) begin
            @(negedge clk);
            n++;
        end
        ok = !bg_n;
        if (!ok) report_timeout("bg_n to fall after br_n");
    endtask

    // Reads the whole RAM back and compares it with the reference copy
    task automatic compare_memory(input int src, input int dst, input int count);
        logic [15:0] got;
        logic [15:0] exp;
        for (int w = 0; w < RAM_WORDS; w++) begin
            host_read(w, got);
            exp = expected_word(w, src, dst, count);
            next_image[w] = exp;
            check_count++;
            if (got !== exp) begin
                error_count++;
                $display("[FAIL] host_rdata word %h: got %h, expected %h", w, got, exp);
            end
        end
        for (int w = 0; w < RAM_WORDS; w++) image[w] = next_image[w];
    endtask

    // Copy scenarios, cut short by a timeout
    task automatic run_copies();
        int          done_base;
        int          as_base;
        logic [15:0] word;
        logic        ok;
        done_base = done_count;                 // Even length, supervisor
        start_copy(24'h040, 24'h200, 40, 1'b1);
        wait_done(done_base, ok);
        if (!ok) return;
        compare_memory(24'h040, 24'h200, 40);

        done_base = done_count;                 // Odd length, user
        start_copy(24'h100, 24'h300, 13, 1'b0);
        wait_done(done_base, ok);
        if (!ok) return;
        host_read(24'h30c / 2, word);           // Word holding the tail byte
        check_value("host_rdata upper tail", 16'(word[15:8]), 16'(image[24'h10c / 2][15:8]));
        check_value("host_rdata lower tail", 16'(word[7:0]), 16'(image[24'h30c / 2][7:0]));
        compare_memory(24'h100, 24'h300, 13);

        done_base = done_count;                 // Bus granted away mid copy
        start_copy(24'h400, 24'h600, 64, 1'b1);
        repeat (12) @(posedge clk);
        br_n <= 1'b0;
        wait_grant(ok);
        if (!ok) return;
        repeat (8) begin
            @(negedge clk);
            check_value("bg_n", 16'(bg_n), 16'h0);  // Grant held while BR low
            check_value("as_n", 16'(as_n), 16'h1);  // Mover frozen
        end
        @(posedge clk);
        br_n <= 1'b1;
        @(posedge clk);                         // Adapter sees BR high
        @(negedge clk);
        check_value("bg_n", 16'(bg_n), 16'h1);
        wait_done(done_base, ok);
        if (!ok) return;
        compare_memory(24'h400, 24'h600, 64);

        done_base = done_count;                 // Zero length
        as_base   = as_low_count;
        start_copy(24'h080, 24'h500, 0, 1'b0);
        wait_done(done_base, ok);
        if (!ok) return;
        repeat (4) @(posedge clk);
        check_value("as_n low cycles", 16'(as_low_count - as_base), 16'h0);
        compare_memory(24'h080, 24'h500, 0);
    endtask

    // Bus monitors
    always @(negedge clk) begin
        if (!rst) begin
            if (done) done_count++;
            if (!as_n) as_low_count++;
            if (!as_n && fc !== (supervisor ? 3'd5 : 3'd1)) begin
                error_count++;
                $display("[FAIL] fc: got %h, expected %h", fc, supervisor ? 3'd5 : 3'd1);
            end
            if (!as_n && !bg_n) begin
                error_count++;
                $display("Bus cycle started while the bus was granted away");
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        src_addr     = '0;
        dst_addr     = '0;
        byte_count   = 16'd0;
        supervisor   = 1'b0;
        br_n         = 1'b1;
        host_we      = 1'b0;
        host_addr    = 16'd0;
        host_wdata   = 16'd0;
        rng_state    = 32'd94491;
        error_count  = 0;
        check_count  = 0;
        done_count   = 0;
        as_low_count = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("as_n", 16'(as_n), 16'h1);  // Idle bus after reset
        check_value("bg_n", 16'(bg_n), 16'h1);
        check_value("busy", 16'(busy), 16'h0);
        check_value("done", 16'(done), 16'h0);
        fill_ram();
        run_copies();
        finish_run();
    end

endmodule

/* tb/mover_system_assertions.sv */
/*
 * 68000 bus protocol assertions
 * Bound into the strobe to 68000 bus adapter. Checks the idle gap after
 * DTACK, the bus grant timing and the data strobe lanes.
 */
module mover_system_assertions (
    input logic clk,
    input logic rst,
    input logic rd_ena,
    input logic wr_ena,
    input logic data_ack,
    input logic bus_busy,
    input logic as_n,
    input logic uds_n,
    input logic lds_n,
    input logic bg_n
);

    // AS returns high after a cycle unless a new strobe is already there
    assert property (@(posedge clk) disable iff (rst)
        data_ack |=> (rd_ena || wr_ena || as_n))
        else $error("as_n stayed low after data_ack without a strobe");

    // No grant while a cycle is running
    assert property (@(posedge clk) disable iff (rst)
        bus_busy |=> !$fell(bg_n))
        else $error("bg_n fell while bus_busy was high");

    // At least one lane active in every bus cycle
    assert property (@(posedge clk) disable iff (rst)
        !as_n |-> !(uds_n && lds_n))
        else $error("uds_n and lds_n both high while as_n low");

endmodule

bind m68k_bus_adapter mover_system_assertions mover_system_assertions_i (
    .clk      (clk),
    .rst      (rst),
    .rd_ena   (rd_ena),
    .wr_ena   (wr_ena),
    .data_ack (data_ack),
    .bus_busy (bus_busy),
    .as_n     (as_n),
    .uds_n    (uds_n),
    .lds_n    (lds_n),
    .bg_n     (bg_n)
);

/* source/mover_system.sv */
/*
 * Block mover subsystem top level
 * Mover as bus master, strobe to 68000 bus adapter,
 * and wait-state RAM with a host port
 */
module mover_system #(
    parameter int WAIT_STATES = 2,
    parameter int RAM_WORDS   = 1024
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic [m68k_bus_pkg::addr_w-1:0]      src_addr,
    input  logic [m68k_bus_pkg::addr_w-1:0]      dst_addr,
    input  logic [15:0]                          byte_count,
    input  logic                                 supervisor,
    input  logic                                 br_n,
    input  logic                                 host_we,
    input  logic [15:0]                          host_addr,
    input  logic [m68k_bus_pkg::data_w-1:0]      host_wdata,
    output logic                                 busy,
    output logic                                 done,
    output logic                                 bg_n,
    output logic                                 as_n,
    output logic [2:0]                           fc,
    output logic [m68k_bus_pkg::data_w-1:0]      host_rdata
);
    import m68k_bus_pkg::*;

    logic                rd_ena;
    logic                wr_ena;
    logic                data_ack;
    logic                cen;               // Master enable from grant
    logic [addr_w-1:0]   address;
    logic [1:0]          byte_ena;
    fc_code_t            mover_fc;
    logic [data_w-1:0]   wr_data;           // Write data bus
    logic [data_w-1:0]   rd_data;           // Read data bus
    logic [addr_w-1:1]   eab;
    logic                uds_n;
    logic                lds_n;
    logic                erw_n;
    logic                dtack_n;

    block_mover block_mover_i (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .byte_count (byte_count),
        .supervisor (supervisor),
        .data_ack   (data_ack),
        .rd_data    (rd_data),
        .rd_ena     (rd_ena),
        .wr_ena     (wr_ena),
        .address    (address),
        .byte_ena   (byte_ena),
        .fc         (mover_fc),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done)
    );

    m68k_bus_adapter m68k_bus_adapter_i (
        .clk      (clk),
        .rst      (rst),
        .rd_ena   (rd_ena),
        .wr_ena   (wr_ena),
        .address  (address),
        .byte_ena (byte_ena),
        .fc_in    (mover_fc),
        .br_n     (br_n),
        .dtack_n  (dtack_n),
        .data_ack (data_ack),
        .cen      (cen),
        .eab      (eab),
        .as_n     (as_n),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .erw_n    (erw_n),
        .fc_out   (fc),
        .bg_n     (bg_n)
    );

    m68k_wait_ram #(
        .WAIT_STATES (WAIT_STATES),
        .RAM_WORDS   (RAM_WORDS)
    ) m68k_wait_ram_i (
        .clk        (clk),
        .rst        (rst),
        .eab        (eab),
        .as_n       (as_n),
        .uds_n      (uds_n),
        .lds_n      (lds_n),
        .erw_n      (erw_n),
        .bus_wdata  (wr_data),
        .bus_rdata  (rd_data),
        .dtack_n    (dtack_n),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

/* source/m68k_wait_ram.sv */
/*
 * 68000 bus word RAM with wait states
 * Answers AS with a single DTACK pulse WAIT_STATES+1 cycles later,
 * with byte-lane writes via UDS/LDS. A synchronous host port
 * shares the array for loading and reading back data.
 */
module m68k_wait_ram #(
    parameter int WAIT_STATES = 2,
    parameter int RAM_WORDS   = 1024
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [m68k_bus_pkg::addr_w-1:1]      eab,
    input  logic                                 as_n,
    input  logic                                 uds_n,
    input  logic                                 lds_n,
    input  logic                                 erw_n,
    input  logic [m68k_bus_pkg::data_w-1:0]      bus_wdata,
    output logic [m68k_bus_pkg::data_w-1:0]      bus_rdata,
    output logic                                 dtack_n,
    input  logic                                 host_we,
    input  logic [15:0]                          host_addr,
    input  logic [m68k_bus_pkg::data_w-1:0]      host_wdata,
    output logic [m68k_bus_pkg::data_w-1:0]      host_rdata
);
    localparam int idx_w = $clog2(RAM_WORDS);
    localparam int cnt_w = $clog2(WAIT_STATES + 2);

    logic [15:0]       mem [RAM_WORDS];
    logic [idx_w-1:0]  bus_idx;
    logic [idx_w-1:0]  host_idx;
    logic [cnt_w-1:0]  cnt;                 // Cycles since AS seen
    logic              active;              // Counting wait states
    logic              acked;               // DTACK given, wait for AS high
    logic              fire;                // Complete the bus cycle
    logic              we_hi;
    logic              we_lo;
    logic [idx_w-1:0]  w_idx;
    logic [15:0]       w_data;

    assign bus_idx  = eab[idx_w:1];
    assign host_idx = host_addr[idx_w-1:0];

    always_comb begin
        if (active) begin
            fire = (cnt == cnt_w'(WAIT_STATES));
        end else begin
            fire = !as_n && !acked && (WAIT_STATES == 0);   // No wait states
        end
    end

    // Single write port, host has priority
    assign we_hi  = host_we | (fire & ~erw_n & ~uds_n);
    assign we_lo  = host_we | (fire & ~erw_n & ~lds_n);
    assign w_idx  = host_we ? host_idx : bus_idx;
    assign w_data = host_we ? host_wdata : bus_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            acked   <= 1'b0;
            cnt     <= '0;
            dtack_n <= 1'b1;
        end else begin
            dtack_n <= 1'b1;                // One-cycle DTACK
            if (as_n) begin
                active <= 1'b0;
                acked  <= 1'b0;
            end else if (fire) begin
                dtack_n <= 1'b0;
                active  <= 1'b0;
                acked   <= 1'b1;
            end else if (!active && !acked) begin
                active <= 1'b1;             // First cycle with AS low
                cnt    <= cnt_w'(1);
            end else if (active) begin
                cnt <= cnt + cnt_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_hi) mem[w_idx][15:8] <= w_data[15:8];
        if (we_lo) mem[w_idx][7:0]  <= w_data[7:0];
        if (fire && erw_n) begin
            bus_rdata <= mem[bus_idx];      // Valid alongside DTACK
        end
        host_rdata <= mem[host_idx];
    end

endmodule

/* source/m68k_bus_adapter.sv */
/*
 * Strobe to 68000 bus adapter
 * Turns master read/write strobes into AS, UDS, LDS and R/W,
 * tracks the busy bus cycle, and hands the bus to an outside
 * requester through BR/BG, freezing the master while granted.
 */
module m68k_bus_adapter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 rd_ena,
    input  logic                                 wr_ena,
    input  logic [m68k_bus_pkg::addr_w-1:0]      address,
    input  logic [1:0]                           byte_ena,
    input  m68k_bus_pkg::fc_code_t               fc_in,
    input  logic                                 br_n,
    input  logic                                 dtack_n,
    output logic                                 data_ack,
    output logic                                 cen,
    output logic [m68k_bus_pkg::addr_w-1:1]      eab,
    output logic                                 as_n,
    output logic                                 uds_n,
    output logic                                 lds_n,
    output logic                                 erw_n,
    output logic [2:0]                           fc_out,
    output logic                                 bg_n
);
    import m68k_bus_pkg::*;

    logic bus_busy;                         // Cycle in progress after strobe
    logic wr_cycle;                         // Direction of current cycle
    logic strobe;
    logic grant;                            // Bus can be handed over now

    assign strobe   = rd_ena | wr_ena;
    assign as_n     = ~(strobe | bus_busy);             // Falls with the strobe
    assign uds_n    = as_n | ~byte_ena[1];              // Even byte, D15..D8
    assign lds_n    = as_n | ~byte_ena[0];              // Odd byte, D7..D0
    assign erw_n    = ~(wr_ena | (bus_busy & wr_cycle)); // Low for whole write
    assign eab      = address[addr_w-1:1];
    assign fc_out   = fc_in;
    assign data_ack = ~dtack_n & bus_busy;

    // Only between bus cycles, never against a fresh strobe
    assign grant = ~br_n & ~bus_busy & ~strobe;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_busy <= 1'b0;
            wr_cycle <= 1'b0;
        end else begin
            if (strobe) begin
                bus_busy <= 1'b1;
                wr_cycle <= wr_ena;
            end else if (data_ack) begin
                bus_busy <= 1'b0;           // Ends after DTACK cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bg_n <= 1'b1;
            cen  <= 1'b0;
        end else begin
            if (grant) begin
                bg_n <= 1'b0;
            end else if (br_n) begin
                bg_n <= 1'b1;               // Release after BR rises
            end
            // Follows BG, but drops together with a new grant so
            // the master cannot strobe in the grant cycle
            cen <= bg_n & ~grant;
        end
    end

endmodule

/* source/block_mover.sv */
/*
 * Block mover
 * Strobe-style bus master that copies a byte block one word at a time,
 * a read from the source followed by a write to the destination.
 * A trailing odd byte travels on the upper lane only (big-endian bus).
 */
module block_mover (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cen,
    input  logic                                 start,
    input  logic [m68k_bus_pkg::addr_w-1:0]      src_addr,
    input  logic [m68k_bus_pkg::addr_w-1:0]      dst_addr,
    input  logic [15:0]                          byte_count,
    input  logic                                 supervisor,
    input  logic                                 data_ack,
    input  logic [m68k_bus_pkg::data_w-1:0]      rd_data,
    output logic                                 rd_ena,
    output logic                                 wr_ena,
    output logic [m68k_bus_pkg::addr_w-1:0]      address,
    output logic [1:0]                           byte_ena,
    output m68k_bus_pkg::fc_code_t               fc,
    output logic [m68k_bus_pkg::data_w-1:0]      wr_data,
    output logic                                 busy,
    output logic                                 done
);
    import m68k_bus_pkg::*;

    mover_state_t        state;
    logic [15:0]         remaining;         // Bytes still to move
    logic [15:0]         step;              // Bytes moved by this word
    logic                hold;              // Idle gap after DTACK
    logic                super_q;           // Latched supervisor mode
    logic                write_phase;
    logic [addr_w-1:0]   src_ptr;
    logic [addr_w-1:0]   dst_ptr;
    logic [data_w-1:0]   rd_word;           // Word in flight

    // Odd tail moves one byte, otherwise a full word
    assign step        = (remaining == 16'd1) ? 16'd1 : 16'd2;
    assign byte_ena    = (remaining == 16'd1) ? 2'b10 : 2'b11;   // Upper lane = even byte
    assign write_phase = (state == write_req) || (state == write_wait);
    assign address     = write_phase ? dst_ptr : src_ptr;        // Held until DTACK
    assign wr_data     = rd_word;
    assign busy        = (state != idle);

    // Strobes last one enabled cycle; hold keeps AS high between cycles
    assign rd_ena = cen && (state == read_req) && !hold;
    assign wr_ena = cen && (state == write_req) && !hold;

    always_comb begin
        if (super_q) begin
            fc = fc_super_data;
        end else begin
            fc = fc_user_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            remaining <= 16'd0;
            hold      <= 1'b0;
            done      <= 1'b0;
            super_q   <= 1'b0;
        end else begin
            done <= 1'b0;                   // Single-cycle pulse
            hold <= 1'b0;
            if (cen) begin
                case (state)
                    idle: begin
                        if (start) begin
                            super_q <= supervisor;
                            if (byte_count == 16'd0) begin
                                done <= 1'b1;           // Nothing to copy
                            end else begin
                                remaining <= byte_count;
                                state     <= read_req;
                            end
                        end
                    end
                    read_req: begin
                        if (!hold) state <= read_wait;
                    end
                    read_wait: begin
                        if (data_ack) begin
                            hold  <= 1'b1;
                            state <= write_req;
                        end
                    end
                    write_req: begin
                        if (!hold) state <= write_wait;
                    end
                    write_wait: begin
                        if (data_ack) begin
                            hold      <= 1'b1;
                            remaining <= remaining - step;
                            if (remaining <= 16'd2) begin
                                done  <= 1'b1;          // Last word written
                                state <= idle;
                            end else begin
                                state <= read_req;
                            end
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // Address pointers and the captured word
    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == idle && start) begin
                src_ptr <= src_addr;
                dst_ptr <= dst_addr;
            end
            if (state == read_wait && data_ack) begin
                rd_word <= rd_data;     // Bus data valid with DTACK
            end
            if (state == write_wait && data_ack) begin
                src_ptr <= src_ptr + addr_w'(2);
                dst_ptr <= dst_ptr + addr_w'(2);
            end
        end
    end

endmodule

/* source/m68k_bus_pkg.sv */
/*
 * 68000 bus subsystem shared definitions
 * Bus widths, 68000 function codes and the block mover states
 */
package m68k_bus_pkg;

    parameter int addr_w = 24;              // Byte address width
    parameter int data_w = 16;              // Data bus width

    // 68000 FC2..FC0 encodings
    typedef enum logic [2:0] {
        fc_user_data  = 3'd1,               // User data space
        fc_user_prog  = 3'd2,               // User program space
        fc_super_data = 3'd5,               // Supervisor data space
        fc_super_prog = 3'd6,               // Supervisor program space
        fc_int_ack    = 3'd7                // CPU space, interrupt ack
    } fc_code_t;

    // Block mover FSM
    typedef enum logic [2:0] {
        idle,                               // Waiting for start
        read_req,                           // Issue read strobe
        read_wait,                          // Wait for read DTACK
        write_req,                          // Issue write strobe
        write_wait                          // Wait for write DTACK
    } mover_state_t;

endpackage
